/* Bender.yml */
package:
  name: cnn_cmd

sources:
  - source/cnn_cmd_pkg.sv
  - source/cmd_fifo.sv
  - source/cmd_sequencer.sv
  - source/layer_config_regs.sv
  - source/window_scanner.sv
  - source/cnn_cmd_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/cnn_cmd_tb.sv

/* list.f */
source/cnn_cmd_pkg.sv
source/cmd_fifo.sv
source/cmd_sequencer.sv
source/layer_config_regs.sv
source/window_scanner.sv
source/cnn_cmd_top.sv
tests/tb_clock.sv
tests/cnn_cmd_tb.sv

/* source/cmd_fifo.sv */
`timescale 1ns/1ps

module cmd_fifo #(
    parameter int DEPTH = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        i_wr,
    input  logic [31:0] i_wr_data,
    input  logic        i_rd,
    output logic        o_full,
    output logic        o_valid,
    output logic [31:0] o_rd_data
);

    // Pointer and occupancy widths
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [31:0]   mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          empty;
    logic          wr_ok;
    logic          rd_ok;

    assign empty  = (count == '0);
    assign o_full = (count == CW'(DEPTH));

    // Writes into a full buffer and reads from an empty one are ignored
    assign wr_ok = i_wr && !o_full;
    assign rd_ok = i_rd && !empty;

    // Storage
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    // Registered read word, presented one cycle after the pop
    always_ff @(posedge clk) begin
        if (rd_ok) begin
            o_rd_data <= mem[rd_ptr];
        end
    end

    // Pointers, occupancy and the valid pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= rd_ok;
            if (wr_ok) begin
                // Wrap explicitly, depth need not be a power of two
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* source/cmd_sequencer.sv */
`timescale 1ns/1ps

module cmd_sequencer
    import cnn_cmd_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          i_op_en,
    input  logic          i_valid,
    input  logic [31:0]   i_cmd,
    input  logic          i_layer_done,
    output logic          o_rd_en,
    output logic          o_start,
    output layer_fields_t o_fields,
    output seq_state_e    o_state
);

    seq_state_e state;
    seq_state_e state_nxt;

    // Index of the next descriptor word to arrive
    logic [1:0] burst_cnt;
    // Words known to be received, counting the one arriving now
    logic [2:0] words_seen;
    logic       last_word;

    // A read issued last cycle resolves this cycle as a valid pulse or not,
    // so only the read issued now is still open
    assign words_seen = {1'b0, burst_cnt} + {2'b00, i_valid};
    assign last_word  = i_valid && (burst_cnt == 2'(cmd_burst_len - 1));

    // Keep requesting until the whole burst is in, then stop
    // so no word of the next descriptor is popped
    assign o_rd_en = (state == st_cmd_get) && (words_seen < 3'(cmd_burst_len));

    assign o_state = state;

    // State register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // Next state
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (i_op_en) begin
                    state_nxt = st_cmd_get;
                end
            end
            st_cmd_get: begin
                // Wait here as long as the FIFO stays empty
                if (last_word) begin
                    state_nxt = st_op_run;
                end
            end
            st_op_run: begin
                // Back to idle so the next layer can be fetched
                if (i_layer_done) begin
                    state_nxt = st_idle;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    // Burst counter, cleared outside the fetch state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            burst_cnt <= '0;
        end else if (state != st_cmd_get) begin
            burst_cnt <= '0;
        end else if (i_valid) begin
            burst_cnt <= burst_cnt + 1'b1;
        end
    end

    // Start pulse in the cycle after the last word
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_start <= 1'b0;
        end else begin
            o_start <= (state == st_cmd_get) && last_word;
        end
    end

    // Split each word into its layer fields
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_fields <= '0;
        end else if ((state == st_cmd_get) && i_valid) begin
            case (burst_cnt)
                2'd0: begin
                    o_fields.op     <= layer_op_e'(i_cmd[2:0]);
                    o_fields.rsvd   <= i_cmd[3];
                    o_fields.stride <= i_cmd[7:4];
                    o_fields.kernel <= i_cmd[15:8];
                    o_fields.i_side <= i_cmd[23:16];
                    o_fields.o_side <= i_cmd[31:24];
                end
                2'd1: begin
                    o_fields.i_channel <= i_cmd[15:0];
                    o_fields.o_channel <= i_cmd[31:16];
                end
                2'd2: begin
                    o_fields.padding     <= i_cmd[3:0];
                    o_fields.slot        <= i_cmd[7:4];
                    o_fields.kernel_size <= i_cmd[15:8];
                    o_fields.stride2     <= i_cmd[31:16];
                end
                default: ;
            endcase
        end
    end

endmodule

/* source/cnn_cmd_pkg.sv */
package cnn_cmd_pkg;

    // Command words per layer descriptor
    localparam int cmd_burst_len = 3;

    // Layer operation codes carried in bits 2:0 of word 0
    typedef enum logic [2:0] {
        op_idle      = 3'b000,
        op_conv_relu = 3'b001,
        op_max_pool  = 3'b100,
        op_avg_pool  = 3'b101
    } layer_op_e;

    // Sequencer states, one bit per active state
    typedef enum logic [2:0] {
        st_idle    = 3'b000,
        st_cmd_get = 3'b010,
        st_op_run  = 3'b100
    } seq_state_e;

    // Decoded descriptor
    // Declared from the top of word 2 down to the bottom of word 0,
    // so the packed value equals {word2, word1, word0}
    typedef struct packed {
        // Word 2
        logic [15:0] stride2;
        logic [7:0]  kernel_size;
        logic [3:0]  slot;
        logic [3:0]  padding;
        // Word 1
        logic [15:0] o_channel;
        logic [15:0] i_channel;
        // Word 0
        logic [7:0]  o_side;
        logic [7:0]  i_side;
        logic [7:0]  kernel;
        logic [3:0]  stride;
        // Reserved bit 3 of word 0, kept so the struct is 96 bits
        logic        rsvd;
        layer_op_e   op;
    } layer_fields_t;

    // One kernel tap of one output pixel
    typedef struct packed {
        logic [7:0]        o_y;
        logic [7:0]        o_x;
        logic [7:0]        k_y;
        logic [7:0]        k_x;
        // Input coordinates, may go negative inside the padding border
        logic signed [9:0] in_y;
        logic signed [9:0] in_x;
        // Tap falls outside the input map
        logic              pad;
        // Final tap of the layer
        logic              last;
    } tap_t;

endpackage

/* source/cnn_cmd_top.sv */
`timescale 1ns/1ps

module cnn_cmd_top
    import cnn_cmd_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          i_op_en,
    input  logic          i_cmd_wr,
    input  logic [31:0]   i_cmd_data,
    output logic          o_cmd_full,
    output seq_state_e    o_state,
    output layer_fields_t o_cfg,
    output logic          o_busy,
    output logic [15:0]   o_layer_count,
    output logic [31:0]   o_tap_count,
    output logic          o_tap_valid,
    output tap_t          o_tap
);

    // FIFO to sequencer
    logic          fifo_rd;
    logic          fifo_valid;
    logic [31:0]   fifo_data;
    // Sequencer to configuration block
    logic          seq_start;
    layer_fields_t seq_fields;
    logic          layer_done;
    // Configuration block to scanner
    logic          scan_go;
    logic          scan_done;

    cmd_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_cmd_fifo (
        .clk       (clk),
        .rst       (rst),
        .i_wr      (i_cmd_wr),
        .i_wr_data (i_cmd_data),
        .i_rd      (fifo_rd),
        .o_full    (o_cmd_full),
        .o_valid   (fifo_valid),
        .o_rd_data (fifo_data)
    );

    cmd_sequencer u_cmd_sequencer (
        .clk          (clk),
        .rst          (rst),
        .i_op_en      (i_op_en),
        .i_valid      (fifo_valid),
        .i_cmd        (fifo_data),
        .i_layer_done (layer_done),
        .o_rd_en      (fifo_rd),
        .o_start      (seq_start),
        .o_fields     (seq_fields),
        .o_state      (o_state)
    );

    layer_config_regs u_layer_config_regs (
        .clk           (clk),
        .rst           (rst),
        .i_start       (seq_start),
        .i_fields      (seq_fields),
        .i_scan_done   (scan_done),
        .i_tap_valid   (o_tap_valid),
        .o_go          (scan_go),
        .o_cfg         (o_cfg),
        .o_layer_done  (layer_done),
        .o_busy        (o_busy),
        .o_layer_count (o_layer_count),
        .o_tap_count   (o_tap_count)
    );

    window_scanner u_window_scanner (
        .clk         (clk),
        .rst         (rst),
        .i_go        (scan_go),
        .i_cfg       (o_cfg),
        .o_tap_valid (o_tap_valid),
        .o_tap       (o_tap),
        .o_done      (scan_done)
    );

endmodule

/* source/layer_config_regs.sv */
`timescale 1ns/1ps

module layer_config_regs
    import cnn_cmd_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          i_start,
    input  layer_fields_t i_fields,
    input  logic          i_scan_done,
    input  logic          i_tap_valid,
    output logic          o_go,
    output layer_fields_t o_cfg,
    output logic          o_layer_done,
    output logic          o_busy,
    output logic [15:0]   o_layer_count,
    output logic [31:0]   o_tap_count
);

    // Scanner completion goes straight back to the sequencer
    assign o_layer_done = i_scan_done;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_go          <= 1'b0;
            o_cfg         <= '0;
            o_busy        <= 1'b0;
            o_layer_count <= '0;
            o_tap_count   <= '0;
        end else begin
            // Go trails start by one cycle, fields already latched by then
            o_go <= i_start;
            if (i_start) begin
                o_cfg <= i_fields;
            end

            // Busy rises together with go and drops after done
            if (i_start) begin
                o_busy <= 1'b1;
            end else if (i_scan_done) begin
                o_busy <= 1'b0;
            end

            // Status counters for the host
            if (i_scan_done) begin
                o_layer_count <= o_layer_count + 1'b1;
            end
            if (i_tap_valid) begin
                o_tap_count <= o_tap_count + 1'b1;
            end
        end
    end

endmodule

/* source/window_scanner.sv */
`timescale 1ns/1ps

module window_scanner
    import cnn_cmd_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          i_go,
    input  layer_fields_t i_cfg,
    output logic          o_tap_valid,
    output tap_t          o_tap,
    output logic          o_done
);

    logic       running;
    // Done pulse for a layer with no taps
    logic       empty_done;
    logic       empty_layer;

    // Loop counters, k_x innermost
    logic [7:0] oy;
    logic [7:0] ox;
    logic [7:0] ky;
    logic [7:0] kx;
    logic       kx_end;
    logic       ky_end;
    logic       ox_end;
    logic       oy_end;
    logic       tap_last;

    // Coordinate math, wide enough that pad is exact before truncation
    logic [11:0]        oy_mul;
    logic [11:0]        ox_mul;
    logic signed [13:0] in_y_w;
    logic signed [13:0] in_x_w;
    logic signed [13:0] side_w;

    // Idle op, or a degenerate size, gives a layer without taps
    assign empty_layer = (i_cfg.op == op_idle) || (i_cfg.kernel == '0) ||
                         (i_cfg.o_side == '0);

    assign kx_end   = (kx == i_cfg.kernel - 8'd1);
    assign ky_end   = (ky == i_cfg.kernel - 8'd1);
    assign ox_end   = (ox == i_cfg.o_side - 8'd1);
    assign oy_end   = (oy == i_cfg.o_side - 8'd1);
    assign tap_last = kx_end && ky_end && ox_end && oy_end;

    // Loop control
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running    <= 1'b0;
            empty_done <= 1'b0;
            oy         <= '0;
            ox         <= '0;
            ky         <= '0;
            kx         <= '0;
        end else begin
            empty_done <= i_go && empty_layer;
            if (i_go && !empty_layer) begin
                running <= 1'b1;
                oy      <= '0;
                ox      <= '0;
                ky      <= '0;
                kx      <= '0;
            end else if (running) begin
                // All counters wrap to zero on the final tap
                if (tap_last) begin
                    running <= 1'b0;
                end
                kx <= kx_end ? '0 : kx + 8'd1;
                if (kx_end) begin
                    ky <= ky_end ? '0 : ky + 8'd1;
                end
                if (kx_end && ky_end) begin
                    ox <= ox_end ? '0 : ox + 8'd1;
                end
                if (kx_end && ky_end && ox_end) begin
                    oy <= oy_end ? '0 : oy + 8'd1;
                end
            end
        end
    end

    // in = o * stride + k - padding
    assign oy_mul = oy * i_cfg.stride;
    assign ox_mul = ox * i_cfg.stride;
    assign in_y_w = $signed({2'b00, oy_mul}) + $signed({6'd0, ky}) -
                    $signed({10'd0, i_cfg.padding});
    assign in_x_w = $signed({2'b00, ox_mul}) + $signed({6'd0, kx}) -
                    $signed({10'd0, i_cfg.padding});
    assign side_w = $signed({6'd0, i_cfg.i_side});

    // Tap record straight from the counters, one per running cycle
    always_comb begin
        o_tap.o_y  = oy;
        o_tap.o_x  = ox;
        o_tap.k_y  = ky;
        o_tap.k_x  = kx;
        o_tap.in_y = in_y_w[9:0];
        o_tap.in_x = in_x_w[9:0];
        o_tap.pad  = (in_y_w < 0) || (in_y_w >= side_w) ||
                     (in_x_w < 0) || (in_x_w >= side_w);
        o_tap.last = running && tap_last;
    end

    assign o_tap_valid = running;
    // Done lines up with the last tap, or trails go for an empty layer
    assign o_done      = (running && tap_last) || empty_done;

endmodule

/* tests/cnn_cmd_patterns.txt */
// Per layer: descriptor words 0, 1 and 2 on the first line, then the expected
// op stride kernel i_side o_side padding i_channel o_channel slot kernel_size stride2
// Padded 3x3 conv, stride 1
04040311 00080003 00010921
1 1 3 4 4 1 3 8 2 9 1
// 2x2 max pool, stride 2
03060224 00080008 00020430
4 2 2 6 3 0 8 8 3 4 2
// Idle layer, sizes set but no taps
02040310 00010001 00000050
0 1 3 4 2 0 1 1 5 0 0
// 3x3 average pool, stride 2
03070325 00100010 00020910
5 2 3 7 3 0 10 10 1 9 2
// 3x3 conv, stride 2, padded on both borders
04050321 00040002 00020941
1 2 3 5 4 1 2 4 4 9 2

/* tests/cnn_cmd_tb.sv */
`timescale 1ns/1ps

module cnn_cmd_tb
    import cnn_cmd_pkg::*;
();

    localparam int FIFO_DEPTH = 8;
    localparam int NPAT       = 5;
    // Three descriptor words then eleven expected fields per pattern
    localparam int PW         = 14;
    localparam int NWORDS     = NPAT * cmd_burst_len;

    logic          clk;
    logic          rst;
    logic          op_en;
    logic          cmd_wr;
    logic [31:0]   cmd_data;
    logic          cmd_full;
    seq_state_e    state;
    layer_fields_t cfg;
    logic          busy;
    logic [15:0]   layer_count;
    logic [31:0]   tap_count;
    logic          tap_valid;
    tap_t          tap;

    logic [31:0] pat [NPAT*PW];
    int          cycle_cnt   = 0;
    int          cycle_limit = 0;
    // Running sum of expected taps over finished layers
    int          taps_total  = 0;

    tb_clock #(.PERIOD_NS(20)) u_tb_clock (.o_clk(clk));

    cnn_cmd_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut0 (
        .clk           (clk),
        .rst           (rst),
        .i_op_en       (op_en),
        .i_cmd_wr      (cmd_wr),
        .i_cmd_data    (cmd_data),
        .o_cmd_full    (cmd_full),
        .o_state       (state),
        .o_cfg         (cfg),
        .o_busy        (busy),
        .o_layer_count (layer_count),
        .o_tap_count   (tap_count),
        .o_tap_valid   (tap_valid),
        .o_tap         (tap)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // Field f of pattern p in the order op stride kernel i_side o_side padding
    // i_channel o_channel slot kernel_size stride2
    function automatic int fld(input int p, input int f);
        return int'(pat[p*PW + cmd_burst_len + f]);
    endfunction

    // Word k of the flat descriptor stream
    function automatic logic [31:0] desc_word(input int k);
        return pat[(k / cmd_burst_len) * PW + (k % cmd_burst_len)];
    endfunction

    // Idle layers have no taps
    function automatic int tap_total(input int p);
        if (fld(p, 0) == 0) begin
            return 0;
        end
        return fld(p, 4) * fld(p, 4) * fld(p, 2) * fld(p, 2);
    endfunction

    // Single host write held off while the FIFO is full
    task automatic push_word(input logic [31:0] word);
        while (cmd_full) begin
            @(negedge clk);
        end
        cmd_wr   = 1'b1;
        cmd_data = word;
        @(negedge clk);
        cmd_wr   = 1'b0;
    endtask

    // Follows one layer from go to done against the nested loop model
    task automatic check_layer(input int p);
        string tag;
        int    st;
        int    pd;
        int    side;
        int    n;
        int    t;
        int    oy;
        int    ox;
        int    ky;
        int    kx;
        int    ey;
        int    ex;
        int    ay;
        int    ax;
        bit    epad;
        tag  = $sformatf("layer %0d", p);
        st   = fld(p, 1);
        pd   = fld(p, 5);
        side = fld(p, 3);
        n    = tap_total(p);
        while (!busy) begin
            check_value({tag, " tap_valid before go"}, 0, tap_valid);
            @(negedge clk);
        end
        // Decoded fields are latched together with go
        check_value({tag, " op"}, fld(p, 0), cfg.op);
        check_value({tag, " stride"}, fld(p, 1), cfg.stride);
        check_value({tag, " kernel"}, fld(p, 2), cfg.kernel);
        check_value({tag, " i_side"}, fld(p, 3), cfg.i_side);
        check_value({tag, " o_side"}, fld(p, 4), cfg.o_side);
        check_value({tag, " padding"}, fld(p, 5), cfg.padding);
        check_value({tag, " i_channel"}, fld(p, 6), cfg.i_channel);
        check_value({tag, " o_channel"}, fld(p, 7), cfg.o_channel);
        check_value({tag, " slot"}, fld(p, 8), cfg.slot);
        check_value({tag, " kernel_size"}, fld(p, 9), cfg.kernel_size);
        check_value({tag, " stride2"}, fld(p, 10), cfg.stride2);
        check_value({tag, " state at go"}, st_op_run, state);
        check_value({tag, " tap_valid at go"}, 0, tap_valid);
        @(negedge clk);
        if (n == 0) begin
            // Empty layer sees done one cycle after go
            check_value({tag, " tap_valid empty layer"}, 0, tap_valid);
            check_value({tag, " busy empty layer"}, 1, busy);
            @(negedge clk);
        end
        t = 0;
        for (oy = 0; (oy < fld(p, 4)) && (n > 0); oy++) begin
            for (ox = 0; ox < fld(p, 4); ox++) begin
                for (ky = 0; ky < fld(p, 2); ky++) begin
                    for (kx = 0; kx < fld(p, 2); kx++) begin
                        ey   = oy * st + ky - pd;
                        ex   = ox * st + kx - pd;
                        epad = (ey < 0) || (ey >= side) || (ex < 0) || (ex >= side);
                        ay   = $signed(tap.in_y);
                        ax   = $signed(tap.in_x);
                        tag  = $sformatf("layer %0d tap %0d", p, t);
                        check_value({tag, " valid"}, 1, tap_valid);
                        check_value({tag, " busy"}, 1, busy);
                        check_value({tag, " o_y"}, oy, tap.o_y);
                        check_value({tag, " o_x"}, ox, tap.o_x);
                        check_value({tag, " k_y"}, ky, tap.k_y);
                        check_value({tag, " k_x"}, kx, tap.k_x);
                        check_value({tag, " in_y"}, ey, ay);
                        check_value({tag, " in_x"}, ex, ax);
                        check_value({tag, " pad"}, epad, tap.pad);
                        check_value({tag, " last"}, (t == n - 1), tap.last);
                        t++;
                        @(negedge clk);
                    end
                end
            end
        end
        // One cycle after done
        taps_total += n;
        tag = $sformatf("layer %0d end", p);
        check_value({tag, " tap_valid"}, 0, tap_valid);
        check_value({tag, " busy"}, 0, busy);
        check_value({tag, " state"}, st_idle, state);
        check_value({tag, " layer_count"}, p + 1, layer_count);
        check_value({tag, " tap_count"}, taps_total, tap_count);
    endtask

    // Watchdog sized from the pattern lengths
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if ((cycle_limit > 0) && (cycle_cnt >= cycle_limit)) begin
            $display("Timeout: run went past %0d cycles", cycle_limit);
            $display("Simulation failed");
            $fatal(1, "watchdog expired");
        end
    end

    initial begin
        void'($urandom(65));
        rst      = 1'b1;
        op_en    = 1'b0;
        cmd_wr   = 1'b0;
        cmd_data = '0;
        $readmemh("tests/cnn_cmd_patterns.txt", pat);
        if ($isunknown(pat[NPAT*PW-1])) begin
            $display("Pattern file is missing or holds fewer than %0d patterns", NPAT);
            $display("Simulation failed");
            $fatal(1, "no patterns");
        end
        for (int p = 0; p < NPAT; p++) begin
            cycle_limit += tap_total(p) + 20;
        end
        cycle_limit += 200;

        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("reset busy", 0, busy);
        check_value("reset tap_valid", 0, tap_valid);
        check_value("reset layer_count", 0, layer_count);
        check_value("reset tap_count", 0, tap_count);
        check_value("reset state", st_idle, state);

        // Fill the FIFO back to back with the sequencer held off
        for (int k = 0; k < FIFO_DEPTH; k++) begin
            push_word(desc_word(k));
        end
        check_value("full after fill", 1, cmd_full);
        // This word would corrupt the next descriptor if it got in
        cmd_wr   = 1'b1;
        cmd_data = 32'hffff_ffff;
        @(negedge clk);
        cmd_wr   = 1'b0;
        check_value("full after dropped write", 1, cmd_full);
        op_en = 1'b1;

        fork
            begin
                // Remaining words with random gaps
                for (int k = FIFO_DEPTH; k < NWORDS - cmd_burst_len; k++) begin
                    repeat ($urandom_range(3)) @(negedge clk);
                    push_word(desc_word(k));
                end
                // Last descriptor trickles in while the sequencer waits on an empty FIFO
                while ((layer_count != NPAT - 1) || (state != st_cmd_get)) begin
                    @(negedge clk);
                end
                for (int k = NWORDS - cmd_burst_len; k < NWORDS; k++) begin
                    repeat (1 + $urandom_range(3)) @(negedge clk);
                    push_word(desc_word(k));
                end
            end
            begin
                for (int p = 0; p < NPAT; p++) begin
                    check_layer(p);
                end
            end
        join

        check_value("final layer_count", NPAT, layer_count);
        check_value("final tap_count", taps_total, tap_count);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic o_clk
);

    // Starts low, first rising edge after half a period
    initial begin
        o_clk = 1'b0;
    end

    always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule
